// File: rtl/isaPkg.sv
package isaPkg;

    ////////////////////////////////////////
    // Primary opcodes
    ////////////////////////////////////////
    localparam logic [5:0] OP_SPECIAL  = 6'b000000;
    localparam logic [5:0] OP_SPECIAL2 = 6'b011100;
    localparam logic [5:0] OP_J        = 6'b000010;
    localparam logic [5:0] OP_BEQ      = 6'b000100;
    localparam logic [5:0] OP_BNE      = 6'b000101;
    localparam logic [5:0] OP_BLEZ     = 6'b000110;
    localparam logic [5:0] OP_BGTZ     = 6'b000111;
    localparam logic [5:0] OP_ADDI     = 6'b001000;
    localparam logic [5:0] OP_SLTI     = 6'b001010;
    localparam logic [5:0] OP_ORI      = 6'b001101;
    localparam logic [5:0] OP_XORI     = 6'b001110;
    localparam logic [5:0] OP_LB       = 6'b100000;
    localparam logic [5:0] OP_LH       = 6'b100001;
    localparam logic [5:0] OP_LW       = 6'b100011;
    localparam logic [5:0] OP_SB       = 6'b101000;
    localparam logic [5:0] OP_SH       = 6'b101001;
    localparam logic [5:0] OP_SW       = 6'b101011;

    // Funct field, SPECIAL and SPECIAL2
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_MUL  = 6'b000010;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // One instruction word, three ways to read it
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm16;
        } iFmt;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] index26;
        } jFmt;
    } instrWord;

endpackage

// File: rtl/ctrlPkg.sv
package ctrlPkg;

    localparam int ALU_W = 4;

    localparam logic [ALU_W-1:0] ALU_ADD = 4'd0;
    localparam logic [ALU_W-1:0] ALU_SUB = 4'd1;
    localparam logic [ALU_W-1:0] ALU_AND = 4'd2;
    localparam logic [ALU_W-1:0] ALU_OR  = 4'd3;
    localparam logic [ALU_W-1:0] ALU_XOR = 4'd4;
    localparam logic [ALU_W-1:0] ALU_SLT = 4'd5;
    localparam logic [ALU_W-1:0] ALU_SLL = 4'd6;
    localparam logic [ALU_W-1:0] ALU_SRL = 4'd7;
    localparam logic [ALU_W-1:0] ALU_MUL = 4'd8;

    // Load and store width, same values for both directions
    localparam logic [1:0] WID_WORD = 2'd0;
    localparam logic [1:0] WID_HALF = 2'd1;
    localparam logic [1:0] WID_BYTE = 2'd2;

    localparam logic [2:0] BR_NONE   = 3'd0;
    localparam logic [2:0] BR_EQ     = 3'd1;
    localparam logic [2:0] BR_NE     = 3'd2;
    localparam logic [2:0] BR_LEZ    = 3'd3;
    localparam logic [2:0] BR_GTZ    = 3'd4;
    localparam logic [2:0] BR_ALWAYS = 3'd5;

    // Queued op, MSB first:
    //   aluOp, aluSrcImm, shiftByShamt, regWrite, memToReg, memRead, memWrite,
    //   memWidth, branchCond, rsIdx, rtIdx, destIdx, immExt, opPc
    localparam int CTRL_W = ALU_W + 6 + 2 + 3;
    localparam int QWIDTH = CTRL_W + 3 * 5 + 32 + 32;

endpackage

// File: rtl/instrDecoder.sv
module instrDecoder (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instrValid,
    input  isaPkg::instrWord          instr,
    input  logic [31:0]               instrPc,
    output logic                      opValid,
    output logic                      illegalInstr,
    output logic [ctrlPkg::ALU_W-1:0] aluOp,
    output logic                      aluSrcImm,
    output logic                      shiftByShamt,
    output logic                      regWrite,
    output logic                      memToReg,
    output logic                      memRead,
    output logic                      memWrite,
    output logic [1:0]                memWidth,
    output logic [2:0]                branchCond,
    output logic [4:0]                rsIdx,
    output logic [4:0]                rtIdx,
    output logic [4:0]                destIdx,
    output logic [31:0]               immExt,
    output logic [31:0]               opPc
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic [ALU_W-1:0] dAluOp;
    logic             dAluSrcImm;
    logic             dShift;
    logic             dRegWrite;
    logic             dMemToReg;
    logic             dMemRead;
    logic             dMemWrite;
    logic [1:0]       dMemWidth;
    logic [2:0]       dBranchCond;
    logic [4:0]       dDest;
    logic [31:0]      dImm;
    logic             legal;

    ////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////
    always_comb begin
        dAluOp      = ALU_ADD;
        dAluSrcImm  = 1'b0;
        dShift      = 1'b0;
        dRegWrite   = 1'b0;
        dMemToReg   = 1'b0;
        dMemRead    = 1'b0;
        dMemWrite   = 1'b0;
        dMemWidth   = WID_WORD;
        dBranchCond = BR_NONE;
        dDest       = instr.iFmt.rt;
        dImm        = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};
        legal       = 1'b1;
        case (instr.rFmt.opcode)
            OP_SPECIAL: begin
                dDest     = instr.rFmt.rd;
                dRegWrite = 1'b1;
                case (instr.rFmt.funct)
                    FN_ADDU: dAluOp = ALU_ADD;
                    FN_SUBU: dAluOp = ALU_SUB;
                    FN_AND:  dAluOp = ALU_AND;
                    FN_OR:   dAluOp = ALU_OR;
                    FN_SLT:  dAluOp = ALU_SLT;
                    FN_SLL, FN_SRL: begin
                        // Shift rt by the shamt field, carried in the immediate
                        dAluOp     = (instr.rFmt.funct == FN_SLL) ? ALU_SLL : ALU_SRL;
                        dAluSrcImm = 1'b1;
                        dShift     = 1'b1;
                        dImm       = {27'd0, instr.rFmt.shamt};
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_SPECIAL2: begin
                dAluOp    = ALU_MUL;
                dDest     = instr.rFmt.rd;
                dRegWrite = 1'b1;
                legal     = (instr.rFmt.funct == FN_MUL);
            end
            OP_ADDI, OP_SLTI, OP_ORI, OP_XORI: begin
                dAluSrcImm = 1'b1;
                dRegWrite  = 1'b1;
                case (instr.rFmt.opcode)
                    OP_SLTI: dAluOp = ALU_SLT;
                    OP_ORI:  dAluOp = ALU_OR;
                    OP_XORI: dAluOp = ALU_XOR;
                    default: dAluOp = ALU_ADD;
                endcase
                // Logical immediates are zero extended
                if (instr.rFmt.opcode == OP_ORI || instr.rFmt.opcode == OP_XORI) begin
                    dImm = {16'd0, instr.iFmt.imm16};
                end
            end
            OP_LW, OP_LH, OP_LB: begin
                dAluSrcImm = 1'b1;
                dRegWrite  = 1'b1;
                dMemToReg  = 1'b1;
                dMemRead   = 1'b1;
                dMemWidth  = (instr.rFmt.opcode == OP_LW) ? WID_WORD :
                             (instr.rFmt.opcode == OP_LH) ? WID_HALF : WID_BYTE;
            end
            OP_SW, OP_SH, OP_SB: begin
                dAluSrcImm = 1'b1;
                dMemWrite  = 1'b1;
                dMemWidth  = (instr.rFmt.opcode == OP_SW) ? WID_WORD :
                             (instr.rFmt.opcode == OP_SH) ? WID_HALF : WID_BYTE;
            end
            OP_BEQ:  dBranchCond = BR_EQ;
            OP_BNE:  dBranchCond = BR_NE;
            OP_BLEZ: dBranchCond = BR_LEZ;
            OP_BGTZ: dBranchCond = BR_GTZ;
            OP_J: begin
                dBranchCond = BR_ALWAYS;
                dImm        = {6'd0, instr.jFmt.index26};
            end
            default: legal = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            opValid      <= 1'b0;
            illegalInstr <= 1'b0;
        end else begin
            opValid      <= instrValid && legal;
            illegalInstr <= instrValid && !legal;
        end
    end

    // Operand and control payload
    always_ff @(posedge clk) begin
        if (instrValid) begin
            aluOp        <= dAluOp;
            aluSrcImm    <= dAluSrcImm;
            shiftByShamt <= dShift;
            regWrite     <= dRegWrite;
            memToReg     <= dMemToReg;
            memRead      <= dMemRead;
            memWrite     <= dMemWrite;
            memWidth     <= dMemWidth;
            branchCond   <= dBranchCond;
            rsIdx        <= instr.rFmt.rs;
            rtIdx        <= instr.rFmt.rt;
            destIdx      <= dDest;
            immExt       <= dImm;
            opPc         <= instrPc;
        end
    end

    // Branch and jump targets assume word aligned instruction addresses
    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> instrPc[1:0] == 2'b00);

endmodule

// File: rtl/decodeQueue.sv
module decodeQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       push,
    input  logic [ctrlPkg::QWIDTH-1:0] pushData,
    input  logic                       pop,
    output logic [ctrlPkg::QWIDTH-1:0] headData,
    output logic                       opAvail,
    output logic                       stall
);
    localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CW = $clog2(QUEUE_DEPTH + 1);
    localparam logic [PW-1:0] LAST_SLOT = PW'(QUEUE_DEPTH - 1);
    localparam logic [CW-1:0] FULL      = CW'(QUEUE_DEPTH);
    localparam logic [CW-1:0] NEAR_FULL = CW'(QUEUE_DEPTH - 1);

    logic [ctrlPkg::QWIDTH-1:0] slots [QUEUE_DEPTH];
    logic [PW-1:0]              wrPtr;
    logic [PW-1:0]              rdPtr;
    logic [CW-1:0]              count;

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == LAST_SLOT) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == LAST_SLOT) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assign headData = slots[rdPtr];
    assign opAvail  = (count != '0);
    // Leaves room for the op still inside the decoder
    assign stall    = (count >= NEAR_FULL);

    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        count == FULL |-> !push);
    noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
        count == '0 |-> !pop);

endmodule

// File: rtl/execUnit.sv
module execUnit #(
    parameter int MUL_LATENCY = 3,
    parameter int DMEM_WORDS  = 64
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       opAvail,
    input  logic [ctrlPkg::QWIDTH-1:0] headData,
    output logic                       pop,
    output logic                       wbValid,
    output logic [4:0]                 wbReg,
    output logic [31:0]                wbData,
    output logic                       brValid,
    output logic                       brTaken,
    output logic [31:0]                brTarget
);
    import ctrlPkg::*;

    localparam int AW  = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;
    localparam int MCW = $clog2(MUL_LATENCY + 1);

    logic [ALU_W-1:0] aluOp;
    logic             aluSrcImm;
    logic             shiftByShamt;
    logic             regWrite;
    logic             memToReg;
    logic             memRead;
    logic             memWrite;
    logic [1:0]       memWidth;
    logic [2:0]       branchCond;
    logic [4:0]       rsIdx;
    logic [4:0]       rtIdx;
    logic [4:0]       destIdx;
    logic [31:0]      immExt;
    logic [31:0]      opPc;

    logic [31:0] regs [32];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] rsVal;
    logic [31:0] rtVal;
    logic [31:0] opA;
    logic [31:0] opB;
    logic [31:0] aluRes;
    logic [31:0] memWord;
    logic [31:0] loadData;
    logic [31:0] result;
    logic [31:0] pcPlus4;
    logic [AW-1:0] wordAddr;
    logic [MCW-1:0] mulCnt;
    logic [4:0]  mulDest;
    logic [31:0] mulProd;
    logic        taken;
    logic        isMul;

    assign {aluOp, aluSrcImm, shiftByShamt, regWrite, memToReg, memRead, memWrite,
            memWidth, branchCond, rsIdx, rtIdx, destIdx, immExt, opPc} = headData;

    // r0 reads zero whatever was stored
    assign rsVal = (rsIdx == 5'd0) ? 32'd0 : regs[rsIdx];
    assign rtVal = (rtIdx == 5'd0) ? 32'd0 : regs[rtIdx];

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    assign opA = shiftByShamt ? rtVal : rsVal;
    assign opB = aluSrcImm ? immExt : rtVal;

    always_comb begin
        case (aluOp)
            ALU_SUB: aluRes = opA - opB;
            ALU_AND: aluRes = opA & opB;
            ALU_OR:  aluRes = opA | opB;
            ALU_XOR: aluRes = opA ^ opB;
            ALU_SLT: aluRes = {31'd0, $signed(opA) < $signed(opB)};
            ALU_SLL: aluRes = opA << opB[4:0];
            ALU_SRL: aluRes = opA >> opB[4:0];
            ALU_MUL: aluRes = opA * opB;
            default: aluRes = opA + opB;
        endcase
    end

    // Little-endian load with sign extension
    assign wordAddr = aluRes[AW+1:2];
    assign memWord  = dmem[wordAddr];

    always_comb begin
        case (memWidth)
            WID_HALF: loadData = 32'($signed(memWord[16*aluRes[1] +: 16]));
            WID_BYTE: loadData = 32'($signed(memWord[8*aluRes[1:0] +: 8]));
            default:  loadData = memWord;
        endcase
    end

    assign result = memToReg ? loadData : aluRes;

    // Branch condition and target
    assign pcPlus4 = opPc + 32'd4;

    always_comb begin
        case (branchCond)
            BR_EQ:     taken = (rsVal == rtVal);
            BR_NE:     taken = (rsVal != rtVal);
            BR_LEZ:    taken = ($signed(rsVal) <= 0);
            BR_GTZ:    taken = ($signed(rsVal) > 0);
            BR_ALWAYS: taken = 1'b1;
            default:   taken = 1'b0;
        endcase
    end

    assign isMul = (aluOp == ALU_MUL);
    assign pop   = opAvail && (mulCnt == '0);

    ////////////////////////////////////////
    // Writeback, stores and mul countdown
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            brValid <= 1'b0;
            mulCnt  <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else begin
            wbValid <= 1'b0;
            brValid <= 1'b0;
            if (mulCnt != '0) begin
                mulCnt <= mulCnt - 1'b1;
                if (mulCnt == MCW'(1) && mulDest != 5'd0) begin
                    wbValid       <= 1'b1;
                    wbReg         <= mulDest;
                    wbData        <= mulProd;
                    regs[mulDest] <= mulProd;
                end
            end
            if (pop) begin
                if (isMul && MUL_LATENCY > 1) begin
                    mulCnt  <= MCW'(MUL_LATENCY - 1);
                    mulDest <= destIdx;
                    mulProd <= aluRes;
                end else if (regWrite && destIdx != 5'd0) begin
                    wbValid       <= 1'b1;
                    wbReg         <= destIdx;
                    wbData        <= result;
                    regs[destIdx] <= result;
                end
                if (branchCond != BR_NONE) begin
                    brValid  <= 1'b1;
                    brTaken  <= taken;
                    brTarget <= (branchCond == BR_ALWAYS) ?
                                {pcPlus4[31:28], immExt[25:0], 2'b00} :
                                pcPlus4 + {immExt[29:0], 2'b00};
                end
                if (memWrite) begin
                    case (memWidth)
                        WID_HALF: dmem[wordAddr][16*aluRes[1] +: 16] <= rtVal[15:0];
                        WID_BYTE: dmem[wordAddr][8*aluRes[1:0] +: 8] <= rtVal[7:0];
                        default:  dmem[wordAddr] <= rtVal;
                    endcase
                end
            end
        end
    end

    memInRange: assert property (@(posedge clk) disable iff (!rstN)
        pop && (memRead || memWrite) |-> aluRes[31:2] < 30'(DMEM_WORDS));

endmodule

// File: rtl/mipsCore.sv
module mipsCore #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MUL_LATENCY = 3,
    parameter int DMEM_WORDS  = 64
) (
    input  logic             clk,
    input  logic             rstN,
    input  logic             instrValid,
    input  isaPkg::instrWord instr,
    input  logic [31:0]      instrPc,
    output logic             stall,
    output logic             illegalInstr,
    output logic             wbValid,
    output logic [4:0]       wbReg,
    output logic [31:0]      wbData,
    output logic             brValid,
    output logic             brTaken,
    output logic [31:0]      brTarget
);
    import ctrlPkg::*;

    logic             opValid;
    logic [ALU_W-1:0] aluOp;
    logic             aluSrcImm;
    logic             shiftByShamt;
    logic             regWrite;
    logic             memToReg;
    logic             memRead;
    logic             memWrite;
    logic [1:0]       memWidth;
    logic [2:0]       branchCond;
    logic [4:0]       rsIdx;
    logic [4:0]       rtIdx;
    logic [4:0]       destIdx;
    logic [31:0]      immExt;
    logic [31:0]      opPc;
    logic [QWIDTH-1:0] pushData;
    logic [QWIDTH-1:0] headData;
    logic             opAvail;
    logic             pop;

    instrDecoder decoder0 (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .instrPc(instrPc), .opValid(opValid), .illegalInstr(illegalInstr),
        .aluOp(aluOp), .aluSrcImm(aluSrcImm), .shiftByShamt(shiftByShamt),
        .regWrite(regWrite), .memToReg(memToReg), .memRead(memRead),
        .memWrite(memWrite), .memWidth(memWidth), .branchCond(branchCond),
        .rsIdx(rsIdx), .rtIdx(rtIdx), .destIdx(destIdx), .immExt(immExt),
        .opPc(opPc)
    );

    // Field order follows ctrlPkg
    assign pushData = {aluOp, aluSrcImm, shiftByShamt, regWrite, memToReg, memRead,
                       memWrite, memWidth, branchCond, rsIdx, rtIdx, destIdx,
                       immExt, opPc};

    decodeQueue #(.QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .clk(clk), .rstN(rstN), .push(opValid), .pushData(pushData), .pop(pop),
        .headData(headData), .opAvail(opAvail), .stall(stall)
    );

    execUnit #(.MUL_LATENCY(MUL_LATENCY), .DMEM_WORDS(DMEM_WORDS)) exec0 (
        .clk(clk), .rstN(rstN), .opAvail(opAvail), .headData(headData),
        .pop(pop), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .brValid(brValid), .brTaken(brTaken), .brTarget(brTarget)
    );

endmodule

// File: tests/mipsCoreTb.sv
module mipsCoreTb;
    import isaPkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int MUL_LATENCY = 3;
    localparam int DMEM_WORDS  = 64;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;

    logic        clk;
    logic        rstN;
    logic        instrValid;
    instrWord    instr;
    logic [31:0] instrPc;
    logic        stall;
    logic        illegalInstr;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    logic        brValid;
    logic        brTaken;
    logic [31:0] brTarget;

    // Trace contents, all in program order
    logic [31:0] issuePc [$];
    logic [31:0] issueWord [$];
    logic [4:0]  expWbReg [$];
    logic [31:0] expWbData [$];
    logic        expBrTaken [$];
    logic [31:0] expBrTarget [$];
    int          expIllegal;
    int          illegalSeen;
    int          wbErrors;
    int          brErrors;
    int          endErrors;
    logic        stallSeen;
    logic        traceLoaded;
    integer      seed;
    int          gap;
    longint      timeLimit;

    mipsCore #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .MUL_LATENCY(MUL_LATENCY),
        .DMEM_WORDS(DMEM_WORDS)
    ) dut0 (
        .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
        .instrPc(instrPc), .stall(stall), .illegalInstr(illegalInstr),
        .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
        .brValid(brValid), .brTaken(brTaken), .brTarget(brTarget)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Trace file reader
    ////////////////////////////////////////
    task automatic loadTrace();
        integer           fd;
        integer           code;
        logic [7:0]       tag;
        logic [31:0]      fieldA;
        logic [31:0]      fieldB;
        logic [8*160-1:0] restOfLine;
        fd = $fopen("tests/mipsCoreTrace.txt", "r");
        if (fd == 0) begin
            endErrors++;
            $display("Could not open the trace file tests/mipsCoreTrace.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tag);
                if (code == 1) begin
                    case (tag)
                        "I": begin
                            code = $fscanf(fd, "%h %h", fieldA, fieldB);
                            issuePc.push_back(fieldA);
                            issueWord.push_back(fieldB);
                        end
                        "W": begin
                            code = $fscanf(fd, "%d %h", fieldA, fieldB);
                            expWbReg.push_back(fieldA[4:0]);
                            expWbData.push_back(fieldB);
                        end
                        "B": begin
                            code = $fscanf(fd, "%d %h", fieldA, fieldB);
                            expBrTaken.push_back(fieldA[0]);
                            expBrTarget.push_back(fieldB);
                        end
                        "X": expIllegal++;
                        "#": code = $fgets(restOfLine, fd);
                        default: begin
                            endErrors++;
                            $display("Unknown record '%s' in the trace file", tag);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    // Holds off while the queue is near full, then gives a one-cycle strobe
    task automatic issueInstr(input logic [31:0] pc, input logic [31:0] word);
        while (stall) begin
            @(posedge clk);
            #DRIVE_DELAY;
        end
        instrValid = 1'b1;
        instr      = word;
        instrPc    = pc;
        @(posedge clk);
        #DRIVE_DELAY;
        instrValid = 1'b0;
    endtask

    task automatic matchWriteback();
        logic [4:0]  expReg;
        logic [31:0] expData;
        assert (expWbReg.size() != 0) else begin
            wbErrors++;
            $display("Writeback to r%0d at time %0t with no expected writeback left",
                     wbReg, $time);
        end
        if (expWbReg.size() != 0) begin
            expReg  = expWbReg.pop_front();
            expData = expWbData.pop_front();
            assert (wbReg == expReg && wbData == expData) else begin
                wbErrors++;
                $display("** Error at time %0t: writeback r%0d = %h, expected r%0d = %h",
                         $time, wbReg, wbData, expReg, expData);
            end
        end
    endtask

    task automatic checkBranch();
        logic        expTaken;
        logic [31:0] expTarget;
        assert (expBrTaken.size() != 0) else begin
            brErrors++;
            $display("Branch reported at time %0t with no expected branch left", $time);
        end
        if (expBrTaken.size() != 0) begin
            expTaken  = expBrTaken.pop_front();
            expTarget = expBrTarget.pop_front();
            assert (brTaken == expTaken && brTarget == expTarget) else begin
                brErrors++;
                $display("** Error at time %0t: branch taken %0d target %h, expected %0d %h",
                         $time, brTaken, brTarget, expTaken, expTarget);
            end
        end
    endtask

    task automatic printSummary();
        $display("Errors: writeback %0d, branch %0d, end of run %0d",
                 wbErrors, brErrors, endErrors);
    endtask

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (rstN) begin
            if (stall) begin
                stallSeen = 1'b1;
            end
            if (wbValid) begin
                matchWriteback();
            end
            if (brValid) begin
                checkBranch();
            end
            if (illegalInstr) begin
                illegalSeen++;
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        instrPc     = '0;
        seed        = 28;
        expIllegal  = 0;
        illegalSeen = 0;
        wbErrors    = 0;
        brErrors    = 0;
        endErrors   = 0;
        stallSeen   = 1'b0;
        traceLoaded = 1'b0;
        loadTrace();
        timeLimit   = longint'(issueWord.size() * (MUL_LATENCY + 4) + 50) * CLK_PERIOD;
        traceLoaded = 1'b1;
        repeat (8) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        for (int i = 0; i < issueWord.size(); i++) begin
            gap = {$random(seed)} % 3;
            // Back-to-back mul keeps the unit busy so the queue fills up
            if (issueWord[i][31:26] == OP_SPECIAL2) begin
                gap = 0;
            end
            repeat (gap) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
            issueInstr(issuePc[i], issueWord[i]);
        end
        while (expWbReg.size() != 0 || expBrTaken.size() != 0 || illegalSeen < expIllegal) begin
            @(posedge clk);
        end
        // A few more cycles to catch stray events
        repeat (MUL_LATENCY + 4) @(posedge clk);
        assert (illegalSeen == expIllegal) else begin
            endErrors++;
            $display("Saw %0d illegal instruction flags, expected %0d", illegalSeen, expIllegal);
        end
        assert (stallSeen) else begin
            endErrors++;
            $display("The stall output never went high during the run");
        end
        printSummary();
        if (wbErrors + brErrors + endErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (traceLoaded);
        #(timeLimit);
        $display("Timeout at %0t with %0d writebacks and %0d branches still missing",
                 $time, expWbReg.size(), expBrTaken.size());
        printSummary();
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: tests/mipsCoreTrace.txt
# I pc word (hex) | W reg (dec) data (hex) | B taken (dec) target (hex) | X illegal flag
# Expected W and B records are listed in program order
# Registers read zero after reset
I B0001000 00000821
W 1 00000000
I B0001004 00001021
W 2 00000000
# Immediates and R-type ALU ops
I B0001008 2003FFFB
W 3 FFFFFFFB
I B000100C 34048001
W 4 00008001
I B0001010 386500FF
W 5 FFFFFF04
I B0001014 28660001
W 6 00000001
I B0001018 00834021
W 8 00007FFC
I B000101C 00644823
W 9 FFFF7FFA
I B0001020 00A45024
W 10 00008000
I B0001024 00A45825
W 11 FFFFFF05
I B0001028 0060602A
W 12 00000001
I B000102C 00046900
W 13 00080010
I B0001030 00037202
W 14 00FFFFFF
# Write to r0 gives no event
I B0001034 20800001
# Stores then loads at byte address 16
I B0001038 AC090010
I B000103C A0040011
I B0001040 A4050012
I B0001044 8C0F0010
W 15 FF0401FA
I B0001048 84100012
W 16 FFFFFF04
I B000104C 84110010
W 17 000001FA
I B0001050 80120010
W 18 FFFFFFFA
I B0001054 80130011
W 19 00000001
# Multiply run
I B0001058 7064A802
W 21 FFFD7FFB
I B000105C 7084B002
W 22 40010001
I B0001060 712DB802
W 23 FFC7FFA0
I B0001064 72C6C002
W 24 40010001
I B0001068 71CEC802
W 25 FE000001
# Branches and jump
I B000106C 10220003
B 1 B000107C
I B0001070 1064FFFE
B 0 B000106C
I B0001074 14640010
B 1 B00010B8
I B0001078 14220001
B 0 B0001080
I B000107C 1860FFFC
B 1 B0001070
I B0001080 18800002
B 0 B000108C
I B0001084 1C800005
B 1 B000109C
I B0001088 1C200007
B 0 B00010A8
I B000108C 08123456
B 1 B048D158
# Illegal words, r28 must stay zero
I B0001090 FC000000
X
I B0001094 0064E026
X
I B0001098 0380E821
W 29 00000000

// File: all.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/instrDecoder.sv
rtl/decodeQueue.sv
rtl/execUnit.sv
rtl/mipsCore.sv
tests/mipsCoreTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing --assert --top-module mipsCoreTb \
    -Mdir "$BUILD" -o mipsCoreSim -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./"$BUILD"/mipsCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation log has no result line"
    exit 1
fi
exit 0
